// File: echo_top.f
+incdir+include
hw/net_hdr_pkg.sv
hw/echo_ctrl_pkg.sv
hw/eth_rx_filter.sv
hw/ip_udp_rx_filter.sv
hw/echo_buffer.sv
hw/echo_tx_builder.sv
hw/echo_top.sv
testbench/echo_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UDP echo testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module echo_tb \
    -Mdir obj_dir \
    -f echo_top.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vecho_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit 1
fi

echo "Simulation ended with status 0"
exit 0

// File: testbench/echo_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "echo_settings.svh"

module echo_tb;

    // About 12 frames x 300 bytes x stall factor 4, with margin
    localparam int          TIMEOUT_CYCLES = 30000;
    localparam logic [15:0] IPV4           = 16'h0800;

    logic           clk;
    logic           arst_n;
    logic           rx_val;
    logic   [7:0]   rx_data;
    logic           rx_startframe;
    logic           rx_endframe;
    logic           rx_rdy;
    logic           tx_val;
    logic   [7:0]   tx_data;
    logic           tx_startframe;
    logic           tx_endframe;
    logic           tx_rdy;

    logic   [31:0]  rx_rng;
    logic   [31:0]  tx_rng;
    logic           stall_en;
    int             cycles;
    int             frame_idx;
    logic           held;           // Last cycle was a stalled tx beat
    logic   [9:0]   held_beat;

    logic   [7:0]   rx_frame [$];
    logic   [7:0]   reply    [$];
    logic   [9:0]   exp_q    [$];   // {startframe, endframe, data}

    echo_top dut_i (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.rx_val        (rx_val         )
        ,.rx_data       (rx_data        )
        ,.rx_startframe (rx_startframe  )
        ,.rx_endframe   (rx_endframe    )
        ,.rx_rdy        (rx_rdy         )
        ,.tx_val        (tx_val         )
        ,.tx_data       (tx_data        )
        ,.tx_startframe (tx_startframe  )
        ,.tx_endframe   (tx_endframe    )
        ,.tx_rdy        (tx_rdy         )
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] want, input logic [7:0] got);
        assert (got === want) else begin
            $display("[ERROR] %0t ns: %s expected %02h, got %02h", $time, name, want, got);
            abort_run();
        end
    endtask

    // Big endian, n bytes from the low end of v
    task automatic put_rx(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            rx_frame.push_back(v[i*8 +: 8]);
        end
    endtask

    task automatic put_reply(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            reply.push_back(v[i*8 +: 8]);
        end
    endtask

    task automatic send_frame(
        input logic [47:0] dst_mac, input logic [15:0] etype, input logic [7:0] ver_ihl,
        input logic [7:0] proto, input logic [31:0] dst_ip, input logic [15:0] dst_port,
        input logic [15:0] udp_len, input int pay_n, input logic echo, input logic gaps);
        logic [47:0]    src_mac;
        logic [31:0]    src_ip;
        logic [15:0]    src_port;
        logic [31:0]    sum;
        logic           took;
        logic [7:0]     pay [$];
        src_mac  = 48'h0A_1B_2C_00_00_00 + 48'(frame_idx);
        src_ip   = 32'h0A00_0001 + 32'(frame_idx);
        src_port = 16'd40000 + 16'(frame_idx);
        frame_idx++;
        for (int i = 0; i < pay_n; i++) begin
            rx_rng = xorshift32(rx_rng);
            pay.push_back(rx_rng[15:8]);
        end
        rx_frame.delete();
        put_rx(dst_mac, 6);
        put_rx(src_mac, 6);
        put_rx(48'(etype), 2);
        put_rx(48'(ver_ihl), 1);
        put_rx(48'h0, 1);
        put_rx(48'(udp_len + 16'd20), 2);   // IP total length
        put_rx(48'h0, 2);
        put_rx(48'h4000, 2);
        put_rx(48'h40, 1);
        put_rx(48'(proto), 1);
        put_rx(48'h0, 2);                    // Checksum is not checked on receive
        put_rx(48'(src_ip), 4);
        put_rx(48'(dst_ip), 4);
        put_rx(48'(src_port), 2);
        put_rx(48'(dst_port), 2);
        put_rx(48'(udp_len), 2);
        put_rx(48'h0, 2);
        foreach (pay[i]) rx_frame.push_back(pay[i]);

        // ####################
        // Expected reply
        if (echo) begin
            reply.delete();
            put_reply(src_mac, 6);
            put_reply(`LOCAL_MAC, 6);
            put_reply(48'(IPV4), 2);
            put_reply(48'h4500, 2);
            put_reply(48'(16'(pay_n + 28)), 2);
            put_reply(48'h0, 2);
            put_reply(48'h4000, 2);
            put_reply(48'({`IP_TTL, 8'd17}), 2);
            put_reply(48'h0, 2);
            put_reply(48'(`LOCAL_IP), 4);
            put_reply(48'(src_ip), 4);
            put_reply(48'(`ECHO_PORT), 2);
            put_reply(48'(src_port), 2);
            put_reply(48'(16'(pay_n + 8)), 2);
            put_reply(48'h0, 2);
            sum = 32'd0;
            for (int i = 14; i < 34; i += 2) begin
                sum = sum + {16'd0, reply[i], reply[i+1]};
            end
            while (sum[31:16] != 16'd0) begin
                sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
            end
            reply[24] = ~sum[15:8];
            reply[25] = ~sum[7:0];
            foreach (pay[i]) reply.push_back(pay[i]);
            for (int i = 0; i < reply.size(); i++) begin
                exp_q.push_back({i == 0, i == reply.size() - 1, reply[i]});
            end
        end

        for (int i = 0; i < rx_frame.size(); i++) begin
            rx_rng = xorshift32(rx_rng);
            if (gaps && rx_rng[1:0] == 2'd0) begin
                rx_val = 1'b0;
                @(negedge clk);
            end
            rx_val        = 1'b1;
            rx_data       = rx_frame[i];
            rx_startframe = (i == 0);
            rx_endframe   = (i == rx_frame.size() - 1);
            took = 1'b0;
            while (!took) begin
                @(posedge clk);
                took = rx_rdy;
                @(negedge clk);
            end
        end
        rx_val        = 1'b0;
        rx_startframe = 1'b0;
        rx_endframe   = 1'b0;
    endtask

    task automatic good_frame(input int pay_n, input logic gaps);
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'(pay_n + 8), pay_n, 1'b1, gaps);
    endtask

    // Random tx back-pressure
    always @(negedge clk) begin
        if (stall_en) begin
            tx_rng = xorshift32(tx_rng);
            tx_rdy = tx_rng[5:4] != 2'd0;
        end else begin
            tx_rdy = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ####################
    // Output checking
    always @(posedge clk) begin
        logic [9:0] want;
        if (arst_n && held) begin
            check_value("tx_val (stall)", 8'd1, {7'd0, tx_val});
            check_value("tx_data (stall)", held_beat[7:0], tx_data);
            check_value("tx_startframe (stall)", {7'd0, held_beat[9]}, {7'd0, tx_startframe});
            check_value("tx_endframe (stall)", {7'd0, held_beat[8]}, {7'd0, tx_endframe});
        end
        if (arst_n && tx_val && tx_rdy) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected tx beat at %0t ns while no reply byte was expected", $time);
                abort_run();
            end else begin
                want = exp_q.pop_front();
                check_value("tx_data", want[7:0], tx_data);
                check_value("tx_startframe", {7'd0, want[9]}, {7'd0, tx_startframe});
                check_value("tx_endframe", {7'd0, want[8]}, {7'd0, tx_endframe});
            end
        end
        held      = arst_n && tx_val && !tx_rdy;
        held_beat = {tx_startframe, tx_endframe, tx_data};
    end

    initial begin
        int waited;
        stall_en      = 1'b0;
        arst_n        = 1'b0;
        rx_val        = 1'b0;
        rx_data       = 8'h00;
        rx_startframe = 1'b0;
        rx_endframe   = 1'b0;
        tx_rdy        = 1'b1;
        rx_rng        = 32'd90;
        tx_rng        = 32'd90;
        cycles        = 0;
        frame_idx     = 0;
        held          = 1'b0;
        held_beat     = '0;
        clk           = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (rx_rdy && !tx_val && !tx_startframe && !tx_endframe) else begin
            $display("After reset rx_rdy should be high and the tx outputs low");
            abort_run();
        end

        // Echo, then Ethernet level drops
        good_frame(20, 1'b0);
        send_frame(48'h02_00_5E_10_00_99, IPV4, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 20, 1'b0, 1'b0);
        good_frame(20, 1'b0);
        send_frame(`LOCAL_MAC, 16'h86DD, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 20, 1'b0, 1'b0);
        good_frame(20, 1'b0);

        // ####################
        // IP and UDP drops
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, 32'hC0A8_0A03, `ECHO_PORT,
                   16'd28, 20, 1'b0, 1'b0);
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd6, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 20, 1'b0, 1'b0);
        send_frame(`LOCAL_MAC, IPV4, 8'h46, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 20, 1'b0, 1'b0);
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, `LOCAL_IP, 16'd7,
                   16'd28, 20, 1'b0, 1'b0);
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'(`MAX_PAYLOAD + 9), `MAX_PAYLOAD + 1, 1'b0, 1'b0);
        good_frame(16, 1'b0);

        // Short and long payloads must be rewound
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 15, 1'b0, 1'b0);
        good_frame(20, 1'b0);
        send_frame(`LOCAL_MAC, IPV4, 8'h45, 8'd17, `LOCAL_IP, `ECHO_PORT,
                   16'd28, 25, 1'b0, 1'b0);
        good_frame(12, 1'b0);

        // ####################
        // Back to back under stalls and gaps
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        good_frame(`MAX_PAYLOAD, 1'b1);
        good_frame(0, 1'b1);
        good_frame(`MAX_PAYLOAD, 1'b1);
        good_frame(0, 1'b1);
        good_frame(100, 1'b1);
        good_frame(`MAX_PAYLOAD, 1'b1);

        waited = 0;
        while (exp_q.size() != 0 && waited < 5000) begin
            @(negedge clk);
            waited++;
        end
        repeat (50) @(negedge clk);     // Room for any stray reply beat
        if (exp_q.size() != 0) begin
            $display("%0d expected reply bytes never appeared on tx", exp_q.size());
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hw/echo_top.sv
`timescale 1ns/100ps
`default_nettype none

module echo_top import net_hdr_pkg::*; (
     input  logic   clk
    ,input  logic   arst_n

    ,input  logic   rx_val
    ,input  byte_t  rx_data
    ,input  logic   rx_startframe
    ,input  logic   rx_endframe
    ,output logic   rx_rdy

    ,output logic   tx_val
    ,output byte_t  tx_data
    ,output logic   tx_startframe
    ,output logic   tx_endframe
    ,input  logic   tx_rdy
);

    logic       ip_val;
    byte_t      ip_data;
    logic       ip_last;
    logic       ip_rdy;
    mac_addr_t  eth_peer_mac;

    logic       pay_val;
    byte_t      pay_data;
    logic       pay_rdy;
    logic       frame_commit;
    logic       frame_rewind;
    mac_addr_t  peer_mac;
    ip_addr_t   peer_ip;
    udp_port_t  peer_port;
    len_t       pay_len;

    logic       reply_val;
    mac_addr_t  reply_mac;
    ip_addr_t   reply_ip;
    udp_port_t  reply_port;
    len_t       reply_len;
    logic       reply_rdy;
    logic       rd_en;
    byte_t      rd_data;

    // ####################
    // Rx chain

    eth_rx_filter rx_eth_filter (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.rx_val        (rx_val         )
        ,.rx_data       (rx_data        )
        ,.rx_startframe (rx_startframe  )
        ,.rx_endframe   (rx_endframe    )
        ,.rx_rdy        (rx_rdy         )
        ,.ip_val        (ip_val         )
        ,.ip_data       (ip_data        )
        ,.ip_last       (ip_last        )
        ,.ip_rdy        (ip_rdy         )
        ,.peer_mac      (eth_peer_mac   )
    );

    ip_udp_rx_filter rx_ip_udp_filter (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.ip_val        (ip_val         )
        ,.ip_data       (ip_data        )
        ,.ip_last       (ip_last        )
        ,.ip_rdy        (ip_rdy         )
        ,.peer_mac_in   (eth_peer_mac   )
        ,.pay_val       (pay_val        )
        ,.pay_data      (pay_data       )
        ,.pay_rdy       (pay_rdy        )
        ,.frame_commit  (frame_commit   )
        ,.frame_rewind  (frame_rewind   )
        ,.peer_mac      (peer_mac       )
        ,.peer_ip       (peer_ip        )
        ,.peer_port     (peer_port      )
        ,.pay_len       (pay_len        )
    );

    echo_buffer buffer (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.pay_val       (pay_val        )
        ,.pay_data      (pay_data       )
        ,.pay_rdy       (pay_rdy        )
        ,.frame_commit  (frame_commit   )
        ,.frame_rewind  (frame_rewind   )
        ,.peer_mac      (peer_mac       )
        ,.peer_ip       (peer_ip        )
        ,.peer_port     (peer_port      )
        ,.pay_len       (pay_len        )
        ,.reply_val     (reply_val      )
        ,.reply_mac     (reply_mac      )
        ,.reply_ip      (reply_ip       )
        ,.reply_port    (reply_port     )
        ,.reply_len     (reply_len      )
        ,.reply_rdy     (reply_rdy      )
        ,.rd_en         (rd_en          )
        ,.rd_data       (rd_data        )
    );

    // ####################
    // Tx side

    echo_tx_builder tx_builder (
         .clk           (clk            )
        ,.arst_n        (arst_n         )
        ,.reply_val     (reply_val      )
        ,.reply_mac     (reply_mac      )
        ,.reply_ip      (reply_ip       )
        ,.reply_port    (reply_port     )
        ,.reply_len     (reply_len      )
        ,.reply_rdy     (reply_rdy      )
        ,.rd_en         (rd_en          )
        ,.rd_data       (rd_data        )
        ,.tx_val        (tx_val         )
        ,.tx_data       (tx_data        )
        ,.tx_startframe (tx_startframe  )
        ,.tx_endframe   (tx_endframe    )
        ,.tx_rdy        (tx_rdy         )
    );

endmodule

`default_nettype wire

// File: hw/echo_tx_builder.sv
`timescale 1ns/100ps
`default_nettype none
`include "echo_settings.svh"

module echo_tx_builder import net_hdr_pkg::*, echo_ctrl_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  logic       reply_val
    ,input  mac_addr_t  reply_mac
    ,input  ip_addr_t   reply_ip
    ,input  udp_port_t  reply_port
    ,input  len_t       reply_len
    ,output logic       reply_rdy

    ,output logic       rd_en
    ,input  byte_t      rd_data

    ,output logic       tx_val
    ,output byte_t      tx_data
    ,output logic       tx_startframe
    ,output logic       tx_endframe
    ,input  logic       tx_rdy
);

    localparam int HDR_BYTES = ETH_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES;
    localparam ip_addr_t LOCAL_IP_ADDR = `LOCAL_IP;

    tx_state_e                  state;
    len_t                       beat_cnt;
    mac_addr_t                  r_mac;
    ip_addr_t                   r_ip;
    udp_port_t                  r_port;
    len_t                       r_len;
    len_t                       ip_tot_len;
    len_t                       udp_len;
    logic   [19:0]              csum_acc;
    logic   [16:0]              csum_fold;
    logic   [15:0]              ip_csum;
    byte_t  [0:HDR_BYTES-1]     hdr_bytes;
    logic                       hdr_last;
    logic                       pay_last;
    logic                       xfer;

    assign ip_tot_len = r_len + len_t'(IP_HDR_BYTES + UDP_HDR_BYTES);
    assign udp_len    = r_len + len_t'(UDP_HDR_BYTES);

    // ####################
    // IPv4 header checksum

    always_comb begin
        csum_acc  = 20'h04500 + 20'(ip_tot_len) + 20'h04000       // ID 0, DF set
                  + 20'({`IP_TTL, IP_PROTO_UDP})
                  + 20'(LOCAL_IP_ADDR[31:16]) + 20'(LOCAL_IP_ADDR[15:0])
                  + 20'(r_ip[31:16]) + 20'(r_ip[15:0]);
        csum_fold = 17'(csum_acc[15:0]) + 17'(csum_acc[19:16]);
        ip_csum   = ~(csum_fold[15:0] + 16'(csum_fold[16]));
    end

    assign hdr_bytes = {r_mac, `LOCAL_MAC, ETHERTYPE_IPV4,
                        8'h45, 8'h00, ip_tot_len, 16'h0000, 16'h4000,
                        `IP_TTL, IP_PROTO_UDP, ip_csum,
                        LOCAL_IP_ADDR, r_ip,
                        `ECHO_PORT, r_port, udp_len, 16'h0000};

    // ####################
    // Output stream

    assign hdr_last      = beat_cnt == len_t'(HDR_BYTES - 1);
    assign pay_last      = beat_cnt == r_len - 16'd1;
    assign tx_val        = state != TX_IDLE;
    assign tx_data       = (state == TX_PAYLOAD) ? rd_data : hdr_bytes[beat_cnt[5:0]];
    assign tx_startframe = (state == TX_HDR) && (beat_cnt == '0);
    assign tx_endframe   = (state == TX_HDR) ? (hdr_last && r_len == '0)
                                             : (state == TX_PAYLOAD) && pay_last;
    assign xfer          = tx_val && tx_rdy;
    assign reply_rdy     = (state == TX_IDLE) && reply_val;

    // Next payload byte is fetched as the current beat leaves
    assign rd_en = xfer && ((state == TX_HDR) ? (hdr_last && r_len != '0) : !pay_last);

    always_ff @(posedge clk) begin
        if (reply_rdy) begin
            r_mac  <= reply_mac;
            r_ip   <= reply_ip;
            r_port <= reply_port;
            r_len  <= reply_len;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TX_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    beat_cnt <= '0;
                    if (reply_val) begin
                        state <= TX_HDR;
                    end
                end
                TX_HDR: begin
                    if (tx_rdy && hdr_last) begin
                        beat_cnt <= '0;
                        state    <= (r_len == '0) ? TX_IDLE : TX_PAYLOAD;
                    end else if (tx_rdy) begin
                        beat_cnt <= beat_cnt + 16'd1;
                    end
                end
                default: begin
                    if (tx_rdy && pay_last) begin
                        state <= TX_IDLE;
                    end else if (tx_rdy) begin
                        beat_cnt <= beat_cnt + 16'd1;
                    end
                end
            endcase
        end
    end

    tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_val && !tx_rdy |=> tx_val && $stable(tx_data)
                              && $stable(tx_startframe) && $stable(tx_endframe));

endmodule

`default_nettype wire

// File: hw/echo_buffer.sv
`timescale 1ns/100ps
`default_nettype none
`include "echo_settings.svh"

module echo_buffer import net_hdr_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  logic       pay_val
    ,input  byte_t      pay_data
    ,output logic       pay_rdy

    ,input  logic       frame_commit
    ,input  logic       frame_rewind
    ,input  mac_addr_t  peer_mac
    ,input  ip_addr_t   peer_ip
    ,input  udp_port_t  peer_port
    ,input  len_t       pay_len

    ,output logic       reply_val
    ,output mac_addr_t  reply_mac
    ,output ip_addr_t   reply_ip
    ,output udp_port_t  reply_port
    ,output len_t       reply_len
    ,input  logic       reply_rdy

    ,input  logic       rd_en
    ,output byte_t      rd_data
);

    localparam int AW    = `BUF_ADDR_W;
    localparam int DEPTH = 1 << AW;

    byte_t              mem [DEPTH];
    logic   [AW:0]      wr_ptr;         // Speculative
    logic   [AW:0]      commit_ptr;
    logic   [AW:0]      rd_ptr;
    logic               fifo_full;
    logic               wr_en;

    mac_addr_t          q_mac  [2];
    ip_addr_t           q_ip   [2];
    udp_port_t          q_port [2];
    len_t               q_len  [2];
    logic               q_wr;
    logic               q_rd;
    logic   [1:0]       q_cnt;
    logic               q_pop;

    assign fifo_full = (wr_ptr ^ rd_ptr) == {1'b1, {AW{1'b0}}};
    assign pay_rdy   = !fifo_full && (q_cnt != 2'd2);
    assign wr_en     = pay_val && pay_rdy;

    // ####################
    // Payload FIFO

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= pay_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr[AW-1:0]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
        end else begin
            if (frame_rewind) begin
                wr_ptr <= commit_ptr;   // Bad payload disappears
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (frame_commit) begin
                commit_ptr <= wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ####################
    // Reply queue

    assign q_pop      = reply_val && reply_rdy;
    assign reply_val  = q_cnt != 2'd0;
    assign reply_mac  = q_mac[q_rd];
    assign reply_ip   = q_ip[q_rd];
    assign reply_port = q_port[q_rd];
    assign reply_len  = q_len[q_rd];

    always_ff @(posedge clk) begin
        if (frame_commit) begin
            q_mac[q_wr]  <= peer_mac;
            q_ip[q_wr]   <= peer_ip;
            q_port[q_wr] <= peer_port;
            q_len[q_wr]  <= pay_len;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_wr  <= 1'b0;
            q_rd  <= 1'b0;
            q_cnt <= '0;
        end else begin
            q_wr  <= q_wr ^ frame_commit;
            q_rd  <= q_rd ^ q_pop;
            q_cnt <= q_cnt + 2'(frame_commit) - 2'(q_pop);
        end
    end

    rd_committed: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> rd_ptr != commit_ptr);

    // The IP filter stalls headers while full, so no commit is lost
    no_lost_commit: assert property (@(posedge clk) disable iff (!arst_n)
        frame_commit |-> q_cnt != 2'd2);

endmodule

`default_nettype wire

// File: hw/ip_udp_rx_filter.sv
`timescale 1ns/100ps
`default_nettype none
`include "echo_settings.svh"

module ip_udp_rx_filter import net_hdr_pkg::*, echo_ctrl_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  logic       ip_val
    ,input  byte_t      ip_data
    ,input  logic       ip_last
    ,output logic       ip_rdy
    ,input  mac_addr_t  peer_mac_in

    ,output logic       pay_val
    ,output byte_t      pay_data
    ,input  logic       pay_rdy

    ,output logic       frame_commit
    ,output logic       frame_rewind
    ,output mac_addr_t  peer_mac
    ,output ip_addr_t   peer_ip
    ,output udp_port_t  peer_port
    ,output len_t       pay_len
);

    localparam int HDR_BYTES = IP_HDR_BYTES + UDP_HDR_BYTES;
    localparam int HDR_W     = HDR_BYTES * 8;

    ipu_rx_state_e          state;
    logic   [4:0]           hdr_cnt;
    len_t                   pay_cnt;
    logic   [HDR_W-1:0]     hdr_sr;
    logic   [HDR_W-1:0]     hdr_next;
    len_t                   udp_len;
    logic                   hdr_ok;
    logic                   hdr_done;
    logic                   in_window;
    logic                   beat;

    // Byte n of the header sits at [HDR_W-1-8n -: 8]
    assign hdr_next  = {hdr_sr[HDR_W-9:0], ip_data};
    assign udp_len   = hdr_next[31:16];
    assign hdr_ok    = (hdr_next[223:216] == 8'h45)     // Version 4, IHL 5
                    && (hdr_next[151:144] == IP_PROTO_UDP)
                    && (hdr_next[95:64] == `LOCAL_IP)
                    && (hdr_next[47:32] == `ECHO_PORT)
                    && (udp_len >= len_t'(UDP_HDR_BYTES))
                    && (udp_len <= len_t'(`MAX_PAYLOAD + UDP_HDR_BYTES));

    assign peer_ip   = hdr_sr[127:96];
    assign peer_port = hdr_sr[63:48];
    assign pay_len   = hdr_sr[31:16] - len_t'(UDP_HDR_BYTES);

    assign hdr_done  = hdr_cnt == 5'(HDR_BYTES - 1);
    assign in_window = pay_cnt < pay_len;
    assign pay_val   = (state == IPU_PAYLOAD) && ip_val && in_window;
    assign pay_data  = ip_data;
    assign beat      = ip_val && ip_rdy;

    // Headers also wait on pay_rdy, so a commit never meets a full reply queue
    always_comb begin
        case (state)
            IPU_PAYLOAD: ip_rdy = pay_rdy || !in_window;    // Excess bytes are swallowed
            IPU_DROP:    ip_rdy = 1'b1;
            default:     ip_rdy = pay_rdy;
        endcase
    end

    always_ff @(posedge clk) begin
        if (beat && state == IPU_HDR) begin
            hdr_sr <= hdr_next;
            if (hdr_done) begin
                peer_mac <= peer_mac_in;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= IPU_HDR;
            hdr_cnt      <= '0;
            pay_cnt      <= '0;
            frame_commit <= 1'b0;
            frame_rewind <= 1'b0;
        end else begin
            frame_commit <= 1'b0;
            frame_rewind <= 1'b0;
            if (beat) begin
                case (state)
                    IPU_HDR: begin
                        hdr_cnt <= (hdr_done || ip_last) ? 5'd0 : hdr_cnt + 5'd1;
                        pay_cnt <= '0;
                        if (hdr_done && !ip_last) begin
                            state <= hdr_ok ? IPU_PAYLOAD : IPU_DROP;
                        end
                        // Empty payload ends on the last header byte
                        frame_commit <= hdr_done && ip_last && hdr_ok
                                     && (udp_len == len_t'(UDP_HDR_BYTES));
                    end
                    IPU_PAYLOAD: begin
                        pay_cnt <= pay_cnt + 16'd1;
                        if (ip_last) begin
                            state        <= IPU_HDR;
                            frame_commit <= (pay_cnt + 16'd1) == pay_len;
                            frame_rewind <= (pay_cnt + 16'd1) != pay_len;
                        end
                    end
                    default: begin
                        if (ip_last) begin
                            state <= IPU_HDR;
                        end
                    end
                endcase
            end
        end
    end

    // A commit only follows a header that passed every check
    commit_hdr_ok: assert property (@(posedge clk) disable iff (!arst_n)
        frame_commit |-> (hdr_sr[223:216] == 8'h45) && (hdr_sr[151:144] == IP_PROTO_UDP)
                      && (hdr_sr[95:64] == `LOCAL_IP) && (hdr_sr[47:32] == `ECHO_PORT)
                      && (pay_len <= len_t'(`MAX_PAYLOAD)));

endmodule

`default_nettype wire

// File: hw/eth_rx_filter.sv
`timescale 1ns/100ps
`default_nettype none
`include "echo_settings.svh"

module eth_rx_filter import net_hdr_pkg::*, echo_ctrl_pkg::*; (
     input  logic       clk
    ,input  logic       arst_n

    ,input  logic       rx_val
    ,input  byte_t      rx_data
    ,input  logic       rx_startframe
    ,input  logic       rx_endframe
    ,output logic       rx_rdy

    ,output logic       ip_val
    ,output byte_t      ip_data
    ,output logic       ip_last
    ,input  logic       ip_rdy
    ,output mac_addr_t  peer_mac
);

    localparam int HDR_W = ETH_HDR_BYTES * 8;

    eth_rx_state_e          state;
    logic   [3:0]           hdr_cnt;
    logic   [3:0]           cnt_cur;
    logic   [HDR_W-1:0]     hdr_sr;
    logic   [HDR_W-1:0]     hdr_next;
    logic                   hdr_ok;
    logic                   in_hdr;
    logic                   beat;

    // A startframe byte always opens a new header
    assign ip_val   = (state == ETH_PASS) && rx_val && !rx_startframe;
    assign ip_data  = rx_data;
    assign ip_last  = rx_endframe;
    assign rx_rdy   = (state != ETH_PASS) || ip_rdy || rx_startframe;

    assign beat     = rx_val && rx_rdy;
    assign in_hdr   = (state == ETH_HDR) || rx_startframe;
    assign cnt_cur  = rx_startframe ? 4'd0 : hdr_cnt;
    assign hdr_next = {hdr_sr[HDR_W-9:0], rx_data};
    assign hdr_ok   = (hdr_next[111:64] == `LOCAL_MAC) && (hdr_next[15:0] == ETHERTYPE_IPV4);
    assign peer_mac = hdr_sr[63:16];    // Source MAC, frozen while forwarding

    always_ff @(posedge clk) begin
        if (beat && in_hdr) begin
            hdr_sr <= hdr_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ETH_HDR;
            hdr_cnt <= '0;
        end else if (beat) begin
            if (rx_endframe) begin
                state   <= ETH_HDR;
                hdr_cnt <= '0;
            end else if (in_hdr) begin
                if (cnt_cur == 4'(ETH_HDR_BYTES - 1)) begin
                    state   <= hdr_ok ? ETH_PASS : ETH_DROP;
                    hdr_cnt <= '0;
                end else begin
                    state   <= ETH_HDR;
                    hdr_cnt <= cnt_cur + 4'd1;
                end
            end
        end
    end

    // Forwarding only follows a header that matched
    pass_only: assert property (@(posedge clk) disable iff (!arst_n)
        ip_val |-> (hdr_sr[111:64] == `LOCAL_MAC) && (hdr_sr[15:0] == ETHERTYPE_IPV4));

endmodule

`default_nettype wire

// File: hw/echo_ctrl_pkg.sv
`default_nettype none

package echo_ctrl_pkg;

    typedef enum logic [1:0] {
        ETH_HDR, ETH_PASS, ETH_DROP
    } eth_rx_state_e;

    typedef enum logic [1:0] {
        IPU_HDR, IPU_PAYLOAD, IPU_DROP
    } ipu_rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE, TX_HDR, TX_PAYLOAD
    } tx_state_e;

endpackage

`default_nettype wire

// File: hw/net_hdr_pkg.sv
`default_nettype none

package net_hdr_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  byte_t;

    // ####################
    // Fixed protocol values
    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;  // No options
    localparam int UDP_HDR_BYTES = 8;

endpackage

`default_nettype wire

// File: include/echo_settings.svh
`ifndef ECHO_SETTINGS_SVH
`define ECHO_SETTINGS_SVH

// Station identity
`define LOCAL_MAC       48'h02_00_5E_10_00_01
`define LOCAL_IP        32'hC0A8_0A02
`define ECHO_PORT       16'd65432

// Reply header
`define IP_TTL          8'd64

// Buffering, two maximum payloads fit
`define MAX_PAYLOAD     256
`define BUF_ADDR_W      9

`endif
